// ==== logic/mem_pkg.sv ====
package mem_pkg;

  // command word and register file geometry
  localparam int cmd_w = 32;
  localparam int reg_num_w = 4;
  // ip sits in the last register slot
  localparam logic [reg_num_w-1:0] reg_ip = 4'd15;

  // register number fields
  localparam int s1_num_lsb = 0;
  localparam int s0_num_lsb = 4;
  localparam int d_num_lsb = 8;

  // pointer bits
  localparam int s1_ptr_bit = 16;
  localparam int s0_ptr_bit = 17;
  localparam int d_ptr_bit = 18;

  // flag pairs, two bits each
  localparam int s1_flags_lsb = 20;
  localparam int s0_flags_lsb = 22;
  localparam int d_flags_lsb = 24;

  // opcode in the top nibble
  localparam int opcode_lsb = 28;

  // post-update of a register after the command
  localparam logic [1:0] flag_none = 2'b00;
  localparam logic [1:0] flag_inc = 2'b01;
  localparam logic [1:0] flag_dec = 2'b10;

  // operation handed to one register manager
  typedef enum logic [2:0] {
    op_null,
    op_preexecute,
    op_read,
    op_catch_data,
    op_write,
    op_write_back
  } reg_op_e;

  // operation handed to the fetch unit
  typedef enum logic [1:0] {
    fetch_null,
    fetch_read,
    fetch_update
  } fetch_op_e;

  // command sequencer, listed in walk order
  typedef enum logic [3:0] {
    st_idle,
    st_fetch,
    st_preexecute,
    st_read_s1,
    st_read_s0,
    st_alu,
    st_write_dst,
    st_update_s1,
    st_update_s0,
    st_update_ip,
    st_done
  } seq_state_e;

  typedef enum logic [3:0] {
    opc_mov,
    opc_add,
    opc_sub,
    opc_and
  } opcode_e;

endpackage

// ==== logic/cmd_fetch.sv ====
module cmd_fetch #(
  parameter int data_w = 32,
  parameter int addr_w = 16
) (
  input  logic                      clk,
  input  logic                      rst,
  input  mem_pkg::fetch_op_e        fetch_op,
  input  logic                      bus_done,
  input  logic [data_w-1:0]         bus_rdata,
  input  logic [addr_w-1:0]         base_addr,
  output logic [mem_pkg::cmd_w-1:0] cmd_word,
  output logic                      rd_req,
  output logic                      wr_req,
  output logic [addr_w-1:0]         req_addr,
  output logic [data_w-1:0]         req_wdata,
  output logic                      step_done
);

  typedef enum logic [1:0] {
    f_idle,
    f_rd_ip,
    f_rd_cmd,
    f_wr_ip
  } fetch_state_e;

  fetch_state_e      state;
  // ip as read at the start of the command
  logic [data_w-1:0] ip;
  logic [addr_w-1:0] addr_q;
  logic [data_w-1:0] wdata_q;
  logic [addr_w-1:0] ip_slot;

  // ip slot in data memory
  assign ip_slot = base_addr + addr_w'(mem_pkg::reg_ip);

  // zero when idle so the top can OR all units together
  assign req_addr = (rd_req || wr_req) ? addr_q : '0;
  assign req_wdata = wr_req ? wdata_q : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= f_idle;
      rd_req <= 1'b0;
      wr_req <= 1'b0;
      step_done <= 1'b0;
    end else begin
      step_done <= 1'b0;
      case (state)
        f_idle: begin
          addr_q <= ip_slot;
          if (fetch_op == mem_pkg::fetch_read) begin
            state <= f_rd_ip;
          end else if (fetch_op == mem_pkg::fetch_update) begin
            wdata_q <= ip + 1'b1;
            state <= f_wr_ip;
          end
        end
        default: begin
          if (!rd_req && !wr_req) begin
            // request rises in the second cycle of each phase
            rd_req <= (state != f_wr_ip);
            wr_req <= (state == f_wr_ip);
          end else if (bus_done) begin
            rd_req <= 1'b0;
            wr_req <= 1'b0;
            if (state == f_rd_ip) begin
              // code is addressed by ip directly, no base
              ip <= bus_rdata;
              addr_q <= bus_rdata[addr_w-1:0];
              state <= f_rd_cmd;
            end else begin
              if (state == f_rd_cmd) begin
                cmd_word <= bus_rdata[mem_pkg::cmd_w-1:0];
              end
              step_done <= 1'b1;
              state <= f_idle;
            end
          end
        end
      endcase
    end
  end

endmodule

// ==== logic/register_manager.sv ====
module register_manager #(
  parameter int data_w = 32,
  parameter int addr_w = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  mem_pkg::reg_op_e              reg_op,
  input  logic [mem_pkg::reg_num_w-1:0] reg_num,
  input  logic                          is_ptr,
  input  logic [1:0]                    flags,
  input  logic [addr_w-1:0]             base_addr,
  input  logic [data_w-1:0]             register_in,
  input  logic                          bus_done,
  input  logic [data_w-1:0]             bus_rdata,
  output logic [data_w-1:0]             register_out,
  output logic                          rd_req,
  output logic                          wr_req,
  output logic [addr_w-1:0]             req_addr,
  output logic [data_w-1:0]             req_wdata,
  output logic                          step_done
);

  typedef enum logic [1:0] {
    r_idle,
    r_rd_reg,
    r_rd_ptr,
    r_wr
  } reg_state_e;

  reg_state_e        state;
  // register word itself, the address when is_ptr
  logic [data_w-1:0] reg_val;
  logic              has_reg;
  // operand value or latched result
  logic [data_w-1:0] value;
  // pointer write waiting on the register read
  logic              wr_after;
  logic [addr_w-1:0] addr_q;
  logic [data_w-1:0] wdata_q;
  logic [addr_w-1:0] reg_slot;

  assign reg_slot = base_addr + addr_w'(reg_num);
  assign register_out = value;

  // zero when idle, ORed at the top
  assign req_addr = (rd_req || wr_req) ? addr_q : '0;
  assign req_wdata = wr_req ? wdata_q : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= r_idle;
      rd_req <= 1'b0;
      wr_req <= 1'b0;
      step_done <= 1'b0;
      has_reg <= 1'b0;
      wr_after <= 1'b0;
    end else begin
      step_done <= 1'b0;
      case (state)
        r_idle: begin
          case (reg_op)
            mem_pkg::op_preexecute: begin
              has_reg <= 1'b0;
              value <= '0;
              step_done <= 1'b1;
            end
            mem_pkg::op_read: begin
              addr_q <= reg_slot;
              wr_after <= 1'b0;
              state <= r_rd_reg;
            end
            mem_pkg::op_catch_data: begin
              value <= register_in;
              step_done <= 1'b1;
            end
            mem_pkg::op_write: begin
              wdata_q <= value;
              if (!is_ptr) begin
                addr_q <= reg_slot;
                state <= r_wr;
              end else if (has_reg) begin
                addr_q <= reg_val[addr_w-1:0];
                state <= r_wr;
              end else begin
                // fetch the pointer first
                addr_q <= reg_slot;
                wr_after <= 1'b1;
                state <= r_rd_reg;
              end
            end
            mem_pkg::op_write_back: begin
              addr_q <= reg_slot;
              if (flags == mem_pkg::flag_inc) begin
                wdata_q <= reg_val + 1'b1;
                state <= r_wr;
              end else if (flags == mem_pkg::flag_dec) begin
                wdata_q <= reg_val - 1'b1;
                state <= r_wr;
              end else begin
                // nothing to store back
                step_done <= 1'b1;
              end
            end
            default: begin
            end
          endcase
        end
        default: begin
          if (!rd_req && !wr_req) begin
            rd_req <= (state != r_wr);
            wr_req <= (state == r_wr);
          end else if (bus_done) begin
            rd_req <= 1'b0;
            wr_req <= 1'b0;
            if (state == r_rd_reg) begin
              reg_val <= bus_rdata;
              has_reg <= 1'b1;
              if (wr_after) begin
                addr_q <= bus_rdata[addr_w-1:0];
                wdata_q <= value;
                wr_after <= 1'b0;
                state <= r_wr;
              end else if (is_ptr) begin
                // one level of indirection
                addr_q <= bus_rdata[addr_w-1:0];
                state <= r_rd_ptr;
              end else begin
                value <= bus_rdata;
                step_done <= 1'b1;
                state <= r_idle;
              end
            end else begin
              if (state == r_rd_ptr) begin
                value <= bus_rdata;
              end
              step_done <= 1'b1;
              state <= r_idle;
            end
          end
        end
      endcase
    end
  end

endmodule

// ==== logic/op_sequencer.sv ====
module op_sequencer (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               fetch_done,
  input  logic               s1_done,
  input  logic               s0_done,
  input  logic               d_done,
  input  logic               alu_done,
  output mem_pkg::fetch_op_e fetch_op,
  output mem_pkg::reg_op_e   s1_op,
  output mem_pkg::reg_op_e   s0_op,
  output mem_pkg::reg_op_e   d_op,
  output logic               alu_req,
  output logic               cmd_done
);

  mem_pkg::seq_state_e state;
  mem_pkg::reg_op_e    d_op_q;

  // the alu result is caught by the destination in the very done cycle
  assign d_op = (state == mem_pkg::st_alu && alu_req && alu_done) ?
                mem_pkg::op_catch_data : d_op_q;
  assign cmd_done = (state == mem_pkg::st_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mem_pkg::st_idle;
      fetch_op <= mem_pkg::fetch_null;
      s1_op <= mem_pkg::op_null;
      s0_op <= mem_pkg::op_null;
      d_op_q <= mem_pkg::op_null;
      alu_req <= 1'b0;
    end else begin
      // ops last one cycle
      fetch_op <= mem_pkg::fetch_null;
      s1_op <= mem_pkg::op_null;
      s0_op <= mem_pkg::op_null;
      d_op_q <= mem_pkg::op_null;
      case (state)
        mem_pkg::st_idle: if (start) begin
          fetch_op <= mem_pkg::fetch_read;
          state <= mem_pkg::st_fetch;
        end
        mem_pkg::st_fetch: if (fetch_done) begin
          s1_op <= mem_pkg::op_preexecute;
          s0_op <= mem_pkg::op_preexecute;
          d_op_q <= mem_pkg::op_preexecute;
          state <= mem_pkg::st_preexecute;
        end
        // all three clear in lockstep
        mem_pkg::st_preexecute: if (s1_done && s0_done && d_done) begin
          s1_op <= mem_pkg::op_read;
          state <= mem_pkg::st_read_s1;
        end
        mem_pkg::st_read_s1: if (s1_done) begin
          s0_op <= mem_pkg::op_read;
          state <= mem_pkg::st_read_s0;
        end
        mem_pkg::st_read_s0: if (s0_done) begin
          alu_req <= 1'b1;
          state <= mem_pkg::st_alu;
        end
        mem_pkg::st_alu: begin
          if (alu_req && alu_done) begin
            alu_req <= 1'b0;
          end else if (!alu_req && d_done) begin
            // result latched, store it
            d_op_q <= mem_pkg::op_write;
            state <= mem_pkg::st_write_dst;
          end
        end
        mem_pkg::st_write_dst: if (d_done) begin
          s1_op <= mem_pkg::op_write_back;
          state <= mem_pkg::st_update_s1;
        end
        mem_pkg::st_update_s1: if (s1_done) begin
          s0_op <= mem_pkg::op_write_back;
          state <= mem_pkg::st_update_s0;
        end
        mem_pkg::st_update_s0: if (s0_done) begin
          fetch_op <= mem_pkg::fetch_update;
          state <= mem_pkg::st_update_ip;
        end
        mem_pkg::st_update_ip: if (fetch_done) begin
          state <= mem_pkg::st_done;
        end
        default: state <= mem_pkg::st_idle;
      endcase
    end
  end

endmodule

// ==== logic/mem_bus_port.sv ====
module mem_bus_port #(
  parameter int data_w = 32,
  parameter int addr_w = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              rd_req,
  input  logic              wr_req,
  input  logic [addr_w-1:0] req_addr,
  input  logic [data_w-1:0] req_wdata,
  input  logic              read_dn,
  input  logic              write_dn,
  input  logic              is_bus_busy,
  input  logic [data_w-1:0] data_in,
  output logic              read_q,
  output logic              write_q,
  output logic [addr_w-1:0] addr_out,
  output logic [data_w-1:0] data_out,
  output logic              bus_done,
  output logic [data_w-1:0] bus_rdata
);

  typedef enum logic [1:0] {
    b_idle,
    b_wait,
    b_issued,
    b_done
  } bus_state_e;

  bus_state_e state;
  logic       is_wr;
  logic       issue;

  // goes out in the first free cycle, then stays up until done
  assign issue = (state == b_issued) || (state == b_wait && !is_bus_busy);
  assign read_q = issue && !is_wr;
  assign write_q = issue && is_wr;
  assign bus_done = (state == b_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= b_idle;
      is_wr <= 1'b0;
    end else begin
      case (state)
        b_idle: if (rd_req || wr_req) begin
          // address and data frozen for the whole access
          is_wr <= wr_req;
          addr_out <= req_addr;
          data_out <= req_wdata;
          state <= b_wait;
        end
        b_wait: if (!is_bus_busy) begin
          state <= b_issued;
        end
        b_issued: if (is_wr ? write_dn : read_dn) begin
          bus_rdata <= data_in;
          state <= b_done;
        end
        default: state <= b_idle;
      endcase
    end
  end

endmodule

// ==== logic/mem_manager.sv ====
module mem_manager #(
  parameter int data_w = 32,
  parameter int addr_w = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic [addr_w-1:0] base_addr,
  input  logic [data_w-1:0] data_in,
  input  logic              read_dn,
  input  logic              write_dn,
  input  logic              is_bus_busy,
  input  logic [data_w-1:0] alu_result,
  input  logic              alu_done,
  output logic              read_q,
  output logic              write_q,
  output logic [addr_w-1:0] addr_out,
  output logic [data_w-1:0] data_out,
  output logic              cmd_done,
  output logic              alu_req,
  output mem_pkg::opcode_e  alu_op,
  output logic [data_w-1:0] src1_out,
  output logic [data_w-1:0] src0_out
);

  logic [mem_pkg::cmd_w-1:0] cmd_word;
  mem_pkg::fetch_op_e        fetch_op;
  mem_pkg::reg_op_e          s1_op;
  mem_pkg::reg_op_e          s0_op;
  mem_pkg::reg_op_e          d_op;
  logic                      fetch_done;
  logic                      s1_done;
  logic                      s0_done;
  logic                      d_done;

  // per unit requests
  logic              f_rd;
  logic              f_wr;
  logic              s1_rd;
  logic              s1_wr;
  logic              s0_rd;
  logic              s0_wr;
  logic              d_rd;
  logic              d_wr;
  logic [addr_w-1:0] f_addr;
  logic [addr_w-1:0] s1_addr;
  logic [addr_w-1:0] s0_addr;
  logic [addr_w-1:0] d_addr;
  logic [data_w-1:0] f_wdata;
  logic [data_w-1:0] s1_wdata;
  logic [data_w-1:0] s0_wdata;
  logic [data_w-1:0] d_wdata;
  logic              bus_done;
  logic [data_w-1:0] bus_rdata;

  assign alu_op = mem_pkg::opcode_e'(cmd_word[mem_pkg::opcode_lsb +: $bits(mem_pkg::opcode_e)]);

  op_sequencer i_seq (
    .clk(clk), .rst(rst), .start(start),
    .fetch_done(fetch_done), .s1_done(s1_done), .s0_done(s0_done), .d_done(d_done),
    .alu_done(alu_done), .fetch_op(fetch_op), .s1_op(s1_op), .s0_op(s0_op), .d_op(d_op),
    .alu_req(alu_req), .cmd_done(cmd_done)
  );

  cmd_fetch #(.data_w(data_w), .addr_w(addr_w)) i_fetch (
    .clk(clk), .rst(rst), .fetch_op(fetch_op), .bus_done(bus_done), .bus_rdata(bus_rdata),
    .base_addr(base_addr), .cmd_word(cmd_word), .rd_req(f_rd), .wr_req(f_wr),
    .req_addr(f_addr), .req_wdata(f_wdata), .step_done(fetch_done)
  );

  // sources never catch data, so their register_in is tied off
  register_manager #(.data_w(data_w), .addr_w(addr_w)) s1_mgr (
    .clk(clk), .rst(rst), .reg_op(s1_op),
    .reg_num(cmd_word[mem_pkg::s1_num_lsb +: mem_pkg::reg_num_w]),
    .is_ptr(cmd_word[mem_pkg::s1_ptr_bit]), .flags(cmd_word[mem_pkg::s1_flags_lsb +: 2]),
    .base_addr(base_addr), .register_in('0), .bus_done(bus_done), .bus_rdata(bus_rdata),
    .register_out(src1_out), .rd_req(s1_rd), .wr_req(s1_wr), .req_addr(s1_addr),
    .req_wdata(s1_wdata), .step_done(s1_done)
  );

  register_manager #(.data_w(data_w), .addr_w(addr_w)) s0_mgr (
    .clk(clk), .rst(rst), .reg_op(s0_op),
    .reg_num(cmd_word[mem_pkg::s0_num_lsb +: mem_pkg::reg_num_w]),
    .is_ptr(cmd_word[mem_pkg::s0_ptr_bit]), .flags(cmd_word[mem_pkg::s0_flags_lsb +: 2]),
    .base_addr(base_addr), .register_in('0), .bus_done(bus_done), .bus_rdata(bus_rdata),
    .register_out(src0_out), .rd_req(s0_rd), .wr_req(s0_wr), .req_addr(s0_addr),
    .req_wdata(s0_wdata), .step_done(s0_done)
  );

  // destination value only goes back to memory
  register_manager #(.data_w(data_w), .addr_w(addr_w)) d_mgr (
    .clk(clk), .rst(rst), .reg_op(d_op),
    .reg_num(cmd_word[mem_pkg::d_num_lsb +: mem_pkg::reg_num_w]),
    .is_ptr(cmd_word[mem_pkg::d_ptr_bit]), .flags(cmd_word[mem_pkg::d_flags_lsb +: 2]),
    .base_addr(base_addr), .register_in(alu_result), .bus_done(bus_done),
    .bus_rdata(bus_rdata), .register_out(), .rd_req(d_rd), .wr_req(d_wr),
    .req_addr(d_addr), .req_wdata(d_wdata), .step_done(d_done)
  );

  // one unit at a time, idle units drive zero
  mem_bus_port #(.data_w(data_w), .addr_w(addr_w)) i_port (
    .clk(clk), .rst(rst),
    .rd_req(f_rd | s1_rd | s0_rd | d_rd),
    .wr_req(f_wr | s1_wr | s0_wr | d_wr),
    .req_addr(f_addr | s1_addr | s0_addr | d_addr),
    .req_wdata(f_wdata | s1_wdata | s0_wdata | d_wdata),
    .read_dn(read_dn), .write_dn(write_dn), .is_bus_busy(is_bus_busy), .data_in(data_in),
    .read_q(read_q), .write_q(write_q), .addr_out(addr_out), .data_out(data_out),
    .bus_done(bus_done), .bus_rdata(bus_rdata)
  );

endmodule

// ==== tb/mem_manager_props.sv ====
module mem_manager_props #(
  parameter int addr_w = 16
) (
  input logic              clk,
  input logic              rst,
  input logic              read_q,
  input logic              write_q,
  input logic              read_dn,
  input logic              write_dn,
  input logic [addr_w-1:0] addr_out,
  input logic              alu_req,
  input logic              alu_done,
  input logic [3:0]        alu_op,
  input logic              cmd_done
);

  // one direction at a time
  assert property (@(posedge clk) disable iff (rst) !(read_q && write_q))
    else $error("read_q and write_q high together");

  // address frozen until the access completes
  assert property (@(posedge clk) disable iff (rst)
    (read_q || write_q) && !(read_dn || write_dn) |=> $stable(addr_out))
    else $error("addr_out moved during an access");

  assert property (@(posedge clk) disable iff (rst) read_q && !read_dn |=> read_q)
    else $error("read_q dropped before read_dn");

  assert property (@(posedge clk) disable iff (rst) write_q && !write_dn |=> write_q)
    else $error("write_q dropped before write_dn");

  // alu request and opcode hold until answered
  assert property (@(posedge clk) disable iff (rst) alu_req && !alu_done |=> alu_req)
    else $error("alu_req dropped before alu_done");

  assert property (@(posedge clk) disable iff (rst) alu_req && !alu_done |=> $stable(alu_op))
    else $error("alu_op moved during an alu request");

  assert property (@(posedge clk) disable iff (rst) cmd_done |=> !cmd_done)
    else $error("cmd_done longer than one cycle");

endmodule

bind mem_manager mem_manager_props #(.addr_w(addr_w)) i_props (
  .clk(clk), .rst(rst), .read_q(read_q), .write_q(write_q), .read_dn(read_dn),
  .write_dn(write_dn), .addr_out(addr_out), .alu_req(alu_req), .alu_done(alu_done),
  .alu_op(alu_op), .cmd_done(cmd_done)
);

// ==== tb/tb_mem_manager.sv ====
module tb_mem_manager;

  logic              clk;
  logic              rst;
  logic              start;
  logic [15:0]       base_addr;
  logic [31:0]       data_in;
  logic              read_dn;
  logic              write_dn;
  logic              is_bus_busy;
  logic [31:0]       alu_result;
  logic              alu_done;
  logic              read_q;
  logic              write_q;
  logic [15:0]       addr_out;
  logic [31:0]       data_out;
  logic              cmd_done;
  logic              alu_req;
  mem_pkg::opcode_e  alu_op;
  logic [31:0]       src1_out;
  logic [31:0]       src0_out;

  // flat word memory behind the bus
  logic [31:0] mem [0:65535];
  // expected alu operands, one pair per command in program order
  logic [31:0] alu_src1_q[$];
  logic [31:0] alu_src0_q[$];
  // expected final memory words
  logic [15:0] exp_addr_q[$];
  logic [31:0] exp_word_q[$];
  int          n_cmds = 0;
  int          done_count = 0;
  int          cycles = 0;
  int          limit = 100;
  int          mem_wait = 0;
  int          alu_wait = 0;
  logic        alu_busy = 1'b0;
  logic [31:0] exp_val;
  int unsigned seed_val;

  mem_manager i_dut (
    .clk(clk), .rst(rst), .start(start), .base_addr(base_addr), .data_in(data_in),
    .read_dn(read_dn), .write_dn(write_dn), .is_bus_busy(is_bus_busy),
    .alu_result(alu_result), .alu_done(alu_done), .read_q(read_q), .write_q(write_q),
    .addr_out(addr_out), .data_out(data_out), .cmd_done(cmd_done), .alu_req(alu_req),
    .alu_op(alu_op), .src1_out(src1_out), .src0_out(src0_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
      $display("Finished with errors");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // reference alu, mov passes source 1
  function automatic logic [31:0] alu_calc(input mem_pkg::opcode_e op,
                                           input logic [31:0] a, input logic [31:0] b);
    case (op)
      mem_pkg::opc_mov: return a;
      mem_pkg::opc_add: return a + b;
      mem_pkg::opc_sub: return a - b;
      mem_pkg::opc_and: return a & b;
      default: return '0;
    endcase
  endfunction

  task automatic read_stim;
    int          fd;
    int          n;
    logic [63:0] tag;
    logic [8*256-1:0] line;
    logic [31:0] a_val;
    logic [31:0] w_val;
    fd = $fopen("tb/stim_mem_manager.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file tb/stim_mem_manager.txt");
      $display("Finished with errors");
      $fatal(1, "no stimulus");
    end
    n = $fscanf(fd, "%s", tag);
    while (n == 1) begin
      if (tag == "#") begin
        n = $fgets(line, fd);
      end else if (tag == "p") begin
        n = $fscanf(fd, "%h %h", a_val, w_val);
        mem[a_val[15:0]] = w_val;
      end else if (tag == "c") begin
        n = $fscanf(fd, "%d", n_cmds);
      end else if (tag == "a") begin
        n = $fscanf(fd, "%h %h", a_val, w_val);
        alu_src1_q.push_back(a_val);
        alu_src0_q.push_back(w_val);
      end else if (tag == "e") begin
        n = $fscanf(fd, "%h %h", a_val, w_val);
        exp_addr_q.push_back(a_val[15:0]);
        exp_word_q.push_back(w_val);
      end else begin
        $display("unknown line tag in the stimulus file");
        $display("Finished with errors");
        $fatal(1, "bad stimulus");
      end
      n = $fscanf(fd, "%s", tag);
    end
    $fclose(fd);
  endtask

  // one start pulse, then wait for the end of the command
  task automatic run_command;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (!cmd_done) @(posedge clk);
  endtask

  // memory model with random answer delay and random busy between accesses
  always @(posedge clk) begin
    read_dn <= 1'b0;
    write_dn <= 1'b0;
    if (!rst) begin
      if (!read_q && !write_q) begin
        is_bus_busy <= ($urandom_range(3, 0) == 0);
      end else begin
        is_bus_busy <= 1'b0;
        if (!read_dn && !write_dn) begin
          if (mem_wait != 0) begin
            mem_wait <= mem_wait - 1;
          end else begin
            if (read_q) begin
              data_in <= mem[addr_out];
              read_dn <= 1'b1;
            end else begin
              mem[addr_out] <= data_out;
              write_dn <= 1'b1;
            end
            mem_wait <= $urandom_range(3, 0);
          end
        end
      end
    end
  end

  // alu model, operands checked on the first cycle of each request
  always @(posedge clk) begin
    alu_done <= 1'b0;
    if (!rst && alu_req && !alu_done) begin
      if (!alu_busy) begin
        check_value(32'(alu_src1_q.size() != 0), 32'd1, "alu request beyond the command count");
        exp_val = alu_src1_q.pop_front();
        check_value(src1_out, exp_val, "alu source 1 operand");
        exp_val = alu_src0_q.pop_front();
        check_value(src0_out, exp_val, "alu source 0 operand");
        alu_busy <= 1'b1;
        alu_wait <= $urandom_range(3, 0);
      end else if (alu_wait != 0) begin
        alu_wait <= alu_wait - 1;
      end else begin
        alu_result <= alu_calc(alu_op, src1_out, src0_out);
        alu_done <= 1'b1;
        alu_busy <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && cmd_done) begin
      done_count <= done_count + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, the commands did not complete", cycles);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  initial begin
    seed_val = $urandom(6);
    rst = 1'b1;
    start = 1'b0;
    base_addr = 16'h0100;
    data_in = '0;
    read_dn = 1'b0;
    write_dn = 1'b0;
    is_bus_busy = 1'b0;
    alu_result = '0;
    alu_done = 1'b0;
    // background pattern, preload lines overwrite it
    for (int i = 0; i < 65536; i++) begin
      mem[i] = {~i[15:0], i[15:0]};
    end
    read_stim();
    // longest command runs near 90 cycles with random delays
    limit = 150 * n_cmds + 100;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int c = 0; c < n_cmds; c++) begin
      run_command();
    end
    @(posedge clk);
    check_value(done_count, n_cmds, "cmd_done pulse count");
    check_value(alu_src1_q.size(), 0, "alu requests left unserved");
    foreach (exp_addr_q[i]) begin
      check_value(mem[exp_addr_q[i]], exp_word_q[i],
                  $sformatf("memory word at %h", exp_addr_q[i]));
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== tb/stim_mem_manager.txt ====
# p addr word = preload, c n = command count, a src1 src0 = alu operands per command
# e addr word = final memory word; numbers in hex, registers at 0100, code at 0000
p 0000 10000721
p 0001 20110853
p 0002 30960436
p 0003 00800928
p 0004 10120a47
p 0101 00000010
p 0102 00000003
p 0103 00000200
p 0104 00000300
p 0105 0000000a
p 0106 0000003c
p 0107 ffffffff
p 0108 ffffffff
p 0109 ffffffff
p 010a ffffffff
p 010f 00000000
p 0200 00001234
p 0201 00000f0f
p 0300 ffffffff
c 5
a 00000010 00000003
a 00001234 0000000a
a 0000003c 00000f0f
a 0000122a 00000003
a 00000013 0000000c
e 0101 00000010
e 0102 00000002
e 0103 00000200
e 0104 00000300
e 0105 0000000a
e 0106 0000003d
e 0107 00000014
e 0108 0000122a
e 0109 0000122a
e 010a 0000001f
e 010f 00000005
e 0200 00001234
e 0201 00000f0f
e 0300 0000000c

// ==== tb.f ====
logic/mem_pkg.sv
logic/cmd_fetch.sv
logic/register_manager.sv
logic/op_sequencer.sv
logic/mem_bus_port.sv
logic/mem_manager.sv
tb/mem_manager_props.sv
tb/tb_mem_manager.sv

// ==== Bender.yml ====
package:
  name: mem_manager

sources:
  - logic/mem_pkg.sv
  - logic/cmd_fetch.sv
  - logic/register_manager.sv
  - logic/op_sequencer.sv
  - logic/mem_bus_port.sv
  - logic/mem_manager.sv
  - target: test
    files:
      - tb/mem_manager_props.sv
      - tb/tb_mem_manager.sv
